// File: source/cim_conv_cfg.svh
`ifndef CIM_CONV_CFG_SVH
`define CIM_CONV_CFG_SVH

// Layer geometry
`define CIM_DATA_SIZE       4   // Activation width
`define CIM_XBAR_SIZE       16  // Crossbar rows and columns
`define CIM_OUTPUT_CHANNELS 4   // Output channels per pixel

// Output buffer layout
`define CIM_OBUF_DATA_SIZE  12  // 2*data width + log2(xbar size)
`define CIM_H_TILES         1   // Horizontal tiles
`define CIM_V_TILES         3   // Vertical tiles summed per channel
`define CIM_LANES           2   // Elements read per address
`define CIM_NUM_ADDR        2   // Buffer depth
`define CIM_ADDR_W          1   // Address width

// Accumulator grows by log2 of the three-tile sum
`define CIM_ACC_W           14

// Derived sizes used for array bounds
`define CIM_LANE_CH         2   // Lanes over all horizontal tiles
`define CIM_NUM_BANKS       6   // H tiles * lanes * V tiles
`define CIM_BANK_W          3   // Flat bank index width

`endif

// File: source/cim_types_pkg.sv
`include "cim_conv_cfg.svh"

package cim_types_pkg;

    // One signed partial sum from a crossbar column group
    typedef logic signed [`CIM_OBUF_DATA_SIZE-1:0] psum_t;

    // Sum over the vertical tiles
    typedef logic signed [`CIM_ACC_W-1:0] acc_t;

    // Post-ReLU activation handed to the next layer
    typedef logic [`CIM_DATA_SIZE-1:0] act_t;

    typedef logic [`CIM_ADDR_W-1:0] obuf_addr_t; // Output buffer address

    typedef logic [`CIM_OUTPUT_CHANNELS-1:0] ch_mask_t; // One bit per output channel

    // Flat bank index, (h * lanes + lane) * v_tiles + v
    typedef logic [`CIM_BANK_W-1:0] tile_sel_t;

endpackage

// File: source/layer_ctrl_pkg.sv
package layer_ctrl_pkg;

    // Conversion controller
    typedef enum logic {
        s_conv_idle, // Waiting for an accepted start
        s_conv_busy  // Walking the buffer addresses
    } conv_state_t;

    // Activation buffer occupancy
    typedef enum logic {
        s_pix_empty, // Free for the next conversion
        s_pix_full   // Holding a pixel until popped
    } pix_state_t;

endpackage

// File: source/cim_obuf.sv
`timescale 1ns/1ps
`include "cim_conv_cfg.svh"

module cim_obuf
    import cim_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Load port from the crossbar side
    input  logic       i_load_en,
    input  tile_sel_t  i_load_bank,
    input  obuf_addr_t i_load_addr,
    input  psum_t      i_load_psum,
    input  logic       i_load_commit,

    // Read port toward conv_func
    input  logic       i_done,
    input  obuf_addr_t i_addr,
    output logic       o_cim_ready,
    output psum_t      o_psum [`CIM_NUM_BANKS]
);

    psum_t mem [`CIM_NUM_BANKS][`CIM_NUM_ADDR]; // Partial sums per bank and address

    always_ff @(posedge clk) begin
        if (i_load_en) begin
            mem[i_load_bank][i_load_addr] <= i_load_psum;
        end
    end

    // Every bank is visible at the current address in the same cycle
    always_comb begin
        for (int b = 0; b < `CIM_NUM_BANKS; b++) begin
            o_psum[b] = mem[b][i_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cim_ready <= 1'b0;
        end else if (i_load_commit) begin
            o_cim_ready <= 1'b1; // Crossbar results complete
        end else if (i_done) begin
            o_cim_ready <= 1'b0; // Consumed by conv_func
        end
    end

    // Loads only land while the buffer is not yet handed over, and in a real bank
    a_load_not_ready: assert property (
        @(posedge clk) disable iff (rst)
        i_load_en |-> (!o_cim_ready && (i_load_bank < `CIM_NUM_BANKS))
    ) else $error("cim_obuf: load while ready or to a missing bank");

    // conv_func only finishes a pixel that was committed to it
    a_done_after_commit: assert property (
        @(posedge clk) disable iff (rst)
        i_done |-> o_cim_ready ##1 !o_cim_ready
    ) else $error("cim_obuf: done pulse without a committed buffer");

endmodule

// File: source/conv_func.sv
`timescale 1ns/1ps
`include "cim_conv_cfg.svh"

module conv_func
    import cim_types_pkg::*;
    import layer_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Previous stage
    input  logic       i_start,
    output logic       o_ready,

    // Output buffer
    input  logic       i_cim_ready,
    input  psum_t      i_data [`CIM_NUM_BANKS],
    output obuf_addr_t o_addr,

    // Activation buffer
    input  logic       i_next_ready,
    output act_t       o_data [`CIM_LANE_CH],
    output ch_mask_t   o_write_enable,
    output logic       o_start
);

    localparam ch_mask_t   FIRST_MASK = ch_mask_t'({`CIM_LANE_CH{1'b1}});
    localparam obuf_addr_t LAST_ADDR  = obuf_addr_t'(`CIM_NUM_ADDR - 1);

    conv_state_t state;
    conv_state_t next_state;
    obuf_addr_t  addr;
    obuf_addr_t  next_addr;
    ch_mask_t    next_write_enable;
    acc_t        lane_sum [`CIM_LANE_CH];

    assign o_addr = addr;

    // Sum the vertical tiles of every lane
    always_comb begin
        for (int h = 0; h < `CIM_H_TILES; h++) begin
            for (int l = 0; l < `CIM_LANES; l++) begin
                lane_sum[h*`CIM_LANES+l] = '0;
                for (int v = 0; v < `CIM_V_TILES; v++) begin
                    lane_sum[h*`CIM_LANES+l] = lane_sum[h*`CIM_LANES+l]
                        + acc_t'(i_data[(h*`CIM_LANES+l)*`CIM_V_TILES+v]); // Sign extended
                end
            end
        end
    end

    // ReLU, then keep the low activation bits
    always_comb begin
        for (int i = 0; i < `CIM_LANE_CH; i++) begin
            if (lane_sum[i] > acc_t'(0)) begin
                o_data[i] = lane_sum[i][`CIM_DATA_SIZE-1:0];
            end else begin
                o_data[i] = '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= s_conv_idle;
            addr           <= '0;
            o_write_enable <= '0;
        end else begin
            state          <= next_state;
            addr           <= next_addr;
            o_write_enable <= next_write_enable;
        end
    end

    always_comb begin
        next_state        = state;
        next_addr         = addr;
        next_write_enable = o_write_enable;
        o_ready           = 1'b0;
        o_start           = 1'b0;
        case (state)
            s_conv_idle: begin
                o_ready           = 1'b1;
                next_addr         = '0;
                next_write_enable = '0;
                // Dropped unless both neighbours are ready
                if (i_start && i_cim_ready && i_next_ready) begin
                    next_write_enable = FIRST_MASK; // First channel pair
                    next_state        = s_conv_busy;
                end
            end
            s_conv_busy: begin
                if (addr == LAST_ADDR) begin
                    o_start           = 1'b1; // Last pair written this cycle
                    next_addr         = '0;
                    next_write_enable = '0;
                    next_state        = s_conv_idle;
                end else begin
                    next_addr         = addr + 1'b1;
                    next_write_enable = o_write_enable << `CIM_LANE_CH;
                end
            end
            default: begin
                next_addr         = '0;
                next_write_enable = '0;
                next_state        = s_conv_idle;
            end
        endcase
    end

    a_mask_idle: assert property (
        @(posedge clk) disable iff (rst)
        (state == s_conv_idle) |-> (o_write_enable == '0)
    ) else $error("conv_func: write mask set while idle");

    // Done pulse ends the busy phase on the following edge
    a_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        o_start |-> (state == s_conv_busy) ##1 (state == s_conv_idle)
    ) else $error("conv_func: done pulse outside the last busy cycle");

endmodule

// File: source/act_buffer.sv
`timescale 1ns/1ps
`include "cim_conv_cfg.svh"

module act_buffer
    import cim_types_pkg::*;
    import layer_ctrl_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // From conv_func
    input  act_t     i_data [`CIM_LANE_CH],
    input  ch_mask_t i_write_enable,
    input  logic     i_done,
    output logic     o_next_ready,

    // To the next layer
    input  logic     i_pop,
    output logic     o_pixel_valid,
    output act_t     o_pixel [`CIM_OUTPUT_CHANNELS]
);

    pix_state_t state;

    // Channel c picks lane c mod lane count
    always_ff @(posedge clk) begin
        for (int c = 0; c < `CIM_OUTPUT_CHANNELS; c++) begin
            if (i_write_enable[c]) begin
                o_pixel[c] <= i_data[c % `CIM_LANE_CH];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_pix_empty;
        end else begin
            case (state)
                s_pix_empty: begin
                    if (i_done) begin
                        state <= s_pix_full; // Last channels land with the pulse
                    end
                end
                s_pix_full: begin
                    if (i_pop) begin
                        state <= s_pix_empty;
                    end
                end
                default: state <= s_pix_empty;
            endcase
        end
    end

    assign o_next_ready  = (state == s_pix_empty);
    assign o_pixel_valid = (state == s_pix_full);

    // conv_func must respect the ready level
    a_no_write_full: assert property (
        @(posedge clk) disable iff (rst)
        (state == s_pix_full) |-> (i_write_enable == '0)
    ) else $error("act_buffer: channel write while a pixel is held");

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (rst)
        i_pop |-> (state == s_pix_full)
    ) else $error("act_buffer: pop with no pixel held");

endmodule

// File: source/conv_layer_top.sv
`timescale 1ns/1ps
`include "cim_conv_cfg.svh"

module conv_layer_top
    import cim_types_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Output buffer load port
    input  logic       i_load_en,
    input  tile_sel_t  i_load_bank,
    input  obuf_addr_t i_load_addr,
    input  psum_t      i_load_psum,
    input  logic       i_load_commit,

    // Conversion request
    input  logic       i_start,
    output logic       o_ready,
    output logic       o_cim_ready,

    // Finished pixel toward the next layer
    input  logic       i_pop,
    output logic       o_pixel_valid,
    output act_t       o_pixel [`CIM_OUTPUT_CHANNELS]
);

    obuf_addr_t obuf_addr;
    psum_t      obuf_psum [`CIM_NUM_BANKS];
    act_t       lane_act [`CIM_LANE_CH];
    ch_mask_t   write_enable;
    logic       conv_done;
    logic       next_ready;

    cim_obuf u_obuf (
        .clk           (clk),
        .rst           (rst),
        .i_load_en     (i_load_en),
        .i_load_bank   (i_load_bank),
        .i_load_addr   (i_load_addr),
        .i_load_psum   (i_load_psum),
        .i_load_commit (i_load_commit),
        .i_done        (conv_done),
        .i_addr        (obuf_addr),
        .o_cim_ready   (o_cim_ready),
        .o_psum        (obuf_psum)
    );

    conv_func u_conv_func (
        .clk            (clk),
        .rst            (rst),
        .i_start        (i_start),
        .o_ready        (o_ready),
        .i_cim_ready    (o_cim_ready),
        .i_data         (obuf_psum),
        .o_addr         (obuf_addr),
        .i_next_ready   (next_ready),
        .o_data         (lane_act),
        .o_write_enable (write_enable),
        .o_start        (conv_done)
    );

    act_buffer u_act_buffer (
        .clk            (clk),
        .rst            (rst),
        .i_data         (lane_act),
        .i_write_enable (write_enable),
        .i_done         (conv_done),
        .o_next_ready   (next_ready),
        .i_pop          (i_pop),
        .o_pixel_valid  (o_pixel_valid),
        .o_pixel        (o_pixel)
    );

endmodule

// File: tests/tb_conv_layer.sv
`timescale 1ns/1ps
`include "cim_conv_cfg.svh"

module tb_conv_layer
    import cim_types_pkg::*;
;

    localparam int SEED = 32'h0f8f68b0;

    logic       clk = 1'b0;
    logic       rst;
    logic       i_load_en;
    tile_sel_t  i_load_bank;
    obuf_addr_t i_load_addr;
    psum_t      i_load_psum;
    logic       i_load_commit;
    logic       i_start;
    logic       i_pop;
    logic       o_ready;
    logic       o_cim_ready;
    logic       o_pixel_valid;
    act_t       o_pixel [`CIM_OUTPUT_CHANNELS];

    psum_t psum_model [`CIM_NUM_BANKS][`CIM_NUM_ADDR]; // Sums loaded so far
    act_t  held_pixel [`CIM_OUTPUT_CHANNELS];          // Last converted pixel
    int    line_count = 0;
    int    since_start;  // Falling edges since start was driven
    logic  committed;    // Commit seen since the last conversion
    logic  pixel_held;   // Converted pixel not yet popped

    conv_layer_top UUT (
        .clk(clk), .rst(rst),
        .i_load_en(i_load_en), .i_load_bank(i_load_bank), .i_load_addr(i_load_addr),
        .i_load_psum(i_load_psum), .i_load_commit(i_load_commit),
        .i_start(i_start), .o_ready(o_ready), .o_cim_ready(o_cim_ready),
        .i_pop(i_pop), .o_pixel_valid(o_pixel_valid), .o_pixel(o_pixel)
    );

    always #4 clk = ~clk; // 8 ns period

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            $display(">>> FAIL");
            $fatal(1);
        end
    endtask

    // ReLU on the three-tile sum, then keep the low activation bits
    function automatic act_t expected_act(input int c);
        int sum;
        int lane;
        int a;
        sum  = 0;
        lane = c % `CIM_LANES;
        a    = c / `CIM_LANES;
        for (int v = 0; v < `CIM_V_TILES; v++) begin
            sum += int'(psum_model[lane*`CIM_V_TILES+v][a]);
        end
        if (sum > 0) begin
            return sum[`CIM_DATA_SIZE-1:0];
        end
        return '0;
    endfunction

    task automatic idle_gap();
        repeat ($urandom_range(3, 0)) @(negedge clk);
    endtask

    task automatic load_psum(input int bank, input int addr, input psum_t value);
        i_load_en   = 1'b1;
        i_load_bank = tile_sel_t'(bank);
        i_load_addr = obuf_addr_t'(addr);
        i_load_psum = value;
        psum_model[bank][addr] = value;
        @(negedge clk);
        i_load_en = 1'b0;
    endtask

    task automatic pulse_commit();
        i_load_commit = 1'b1;
        @(negedge clk);
        i_load_commit = 1'b0;
        committed     = 1'b1;
        check_value("o_cim_ready", 32'(o_cim_ready), 32'd1);
    endtask

    task automatic pulse_start();
        i_start     = 1'b1;
        since_start = 0;
        @(negedge clk);
        i_start     = 1'b0;
        since_start = 1;
    endtask

    task automatic pop_pixel();
        check_true(pixel_held, "trace pops while no pixel is held");
        check_value("o_pixel_valid", 32'(o_pixel_valid), 32'd1);
        i_pop = 1'b1;
        @(negedge clk);
        i_pop      = 1'b0;
        pixel_held = 1'b0;
        check_value("o_pixel_valid", 32'(o_pixel_valid), 32'd0); // Free right after the pop
        check_value("o_ready", 32'(o_ready), 32'd1);
    endtask

    task automatic check_pixel(input act_t exp_act [`CIM_OUTPUT_CHANNELS], input int accept);
        for (int c = 0; c < `CIM_OUTPUT_CHANNELS; c++) begin
            check_value($sformatf("trace ch%0d", c), 32'(exp_act[c]), 32'(expected_act(c)));
        end
        check_true((accept != 0) == (committed && !pixel_held),
                   "trace accept flag contradicts the buffer and pixel state");
        if (accept != 0) begin
            while (!o_pixel_valid && since_start < 10) begin
                @(negedge clk);
                since_start++;
            end
            check_true(o_pixel_valid, "accepted start produced no pixel");
            check_value("pixel latency", 32'(since_start), 32'd3);
            for (int c = 0; c < `CIM_OUTPUT_CHANNELS; c++) begin
                check_value($sformatf("o_pixel[%0d]", c), 32'(o_pixel[c]), 32'(exp_act[c]));
                held_pixel[c] = exp_act[c];
            end
            check_value("o_cim_ready", 32'(o_cim_ready), 32'd0); // Consumed by the conversion
            committed  = 1'b0;
            pixel_held = 1'b1;
        end else begin
            // Latency is fixed, so a dropped start shows nothing within these edges
            repeat (4) begin
                check_value("o_ready", 32'(o_ready), 32'd1);
                check_value("o_cim_ready", 32'(o_cim_ready), 32'(committed));
                check_value("o_pixel_valid", 32'(o_pixel_valid), 32'(pixel_held));
                if (pixel_held) begin
                    for (int c = 0; c < `CIM_OUTPUT_CHANNELS; c++) begin
                        check_value($sformatf("o_pixel[%0d]", c), 32'(o_pixel[c]),
                                    32'(held_pixel[c]));
                    end
                end
                @(negedge clk);
            end
        end
    endtask

    initial begin : watchdog
        wait (line_count > 0);
        repeat ((line_count + 8) * 20) @(posedge clk);
        $display("Error: trace replay did not finish before the watchdog limit");
        $display(">>> FAIL");
        $fatal(1);
    end

    initial begin : replay
        int                fd;
        int                code;
        int                bank;
        int                addr;
        int                accept;
        int                cycles;
        logic [11:0]       value;
        logic [7:0]        tag;
        logic [8*256-1:0]  line_buf;
        act_t              exp_act [`CIM_OUTPUT_CHANNELS];

        rst = 1'b1;
        i_load_en = 1'b0;
        i_load_bank = '0;
        i_load_addr = '0;
        i_load_psum = '0;
        i_load_commit = 1'b0;
        i_start = 1'b0;
        i_pop = 1'b0;
        committed = 1'b0;
        pixel_held = 1'b0;
        since_start = 0;
        for (int b = 0; b < `CIM_NUM_BANKS; b++) begin
            for (int a = 0; a < `CIM_NUM_ADDR; a++) begin
                psum_model[b][a] = '0;
            end
        end
        void'($urandom(SEED));

        fd = $fopen("tests/conv_trace.txt", "r");
        check_true(fd != 0, "cannot open tests/conv_trace.txt");
        while (!$feof(fd)) begin
            code = $fgets(line_buf, fd);
            if (code > 0) begin
                line_count++;
            end
        end
        $fclose(fd);
        fd = $fopen("tests/conv_trace.txt", "r");

        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("o_ready", 32'(o_ready), 32'd1);
        check_value("o_cim_ready", 32'(o_cim_ready), 32'd0);
        check_value("o_pixel_valid", 32'(o_pixel_valid), 32'd0);

        code = $fscanf(fd, "%s", tag);
        while (code == 1) begin
            if (tag == "#") begin
                code = $fgets(line_buf, fd); // Rest of a comment line
            end else begin
                if (tag != "E") begin
                    idle_gap(); // E must follow its start directly
                end
                if (tag == "L") begin
                    code = $fscanf(fd, "%d %d %h", bank, addr, value);
                    check_true(code == 3, "malformed L line in trace");
                    load_psum(bank, addr, value);
                end else if (tag == "C") begin
                    pulse_commit();
                end else if (tag == "S") begin
                    pulse_start();
                end else if (tag == "P") begin
                    pop_pixel();
                end else if (tag == "W") begin
                    code = $fscanf(fd, "%d", cycles);
                    check_true(code == 1, "malformed W line in trace");
                    repeat (cycles) @(negedge clk);
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%h %h %h %h %d", exp_act[0], exp_act[1],
                                   exp_act[2], exp_act[3], accept);
                    check_true(code == 5, "malformed E line in trace");
                    check_pixel(exp_act, accept);
                end else begin
                    check_true(1'b0, "unknown tag in trace");
                end
            end
            code = $fscanf(fd, "%s", tag);
        end
        $fclose(fd);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: cim_conv_out.f
+incdir+source
source/cim_types_pkg.sv
source/layer_ctrl_pkg.sv
source/cim_obuf.sv
source/conv_func.sv
source/act_buffer.sv
source/conv_layer_top.sv
tests/tb_conv_layer.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_conv_layer \
    -f cim_conv_out.f

output=$(./obj_dir/Vtb_conv_layer || true)
echo "$output"

if grep -qF ">>> PASS" <<< "$output"; then
    exit 0
fi
exit 1

// File: tests/conv_trace.txt
# Tags: L bank addr psum(hex) | C commit | S start | P pop | W idle_cycles
# E ch0 ch1 ch2 ch3 (hex) accept(1 = start converts, 0 = start dropped)
W 2
L 0 0 001
L 1 0 002
L 2 0 003
L 3 0 004
L 4 0 001
L 5 0 002
L 0 1 002
L 1 1 002
L 2 1 001
L 3 1 003
L 4 1 003
L 5 1 003
C
S
E 6 7 5 9 1
S
E 6 7 5 9 0
P
L 0 0 f00
L 3 0 ffd
L 0 1 7ff
L 1 1 7ff
L 2 1 7ff
L 3 1 00b
S
E 0 0 d 1 0
C
S
E 0 0 d 1 1
C
S
E 0 0 d 1 0
P
S
E 0 0 d 1 1
P
W 3
